// ==== cpu65_pkg.sv ====
package cpu65_pkg;

	// ------------------------------------------------------------------------
	// Datapath width
	// ------------------------------------------------------------------------
	localparam int unsigned DATA_W = 8;

	// ------------------------------------------------------------------------
	// Status byte layout  N V 1 1 D I Z C
	// ------------------------------------------------------------------------
	localparam int unsigned FLAG_N = 7;
	localparam int unsigned FLAG_V = 6;
	localparam int unsigned FLAG_D = 3;
	localparam int unsigned FLAG_I = 2;
	localparam int unsigned FLAG_Z = 1;
	localparam int unsigned FLAG_C = 0;

	// Per-nibble decimal correction
	localparam logic [3:0] BCD_ADJ_ADD = 4'h6;
	localparam logic [3:0] BCD_ADJ_SUB = 4'hA;

	// ------------------------------------------------------------------------
	// Supported opcodes, standard 6502 encodings
	// ------------------------------------------------------------------------
	typedef enum logic [7:0] {
		// Immediate ALU group
		OP_ORA = 8'h09,
		OP_AND = 8'h29,
		OP_EOR = 8'h49,
		OP_ADC = 8'h69,
		OP_LDA = 8'hA9,
		OP_CMP = 8'hC9,
		OP_SBC = 8'hE9,
		// Accumulator shifts, bit 6 selects right, bit 5 selects rotate
		OP_ASL = 8'h0A,
		OP_ROL = 8'h2A,
		OP_LSR = 8'h4A,
		OP_ROR = 8'h6A,
		// Flag operations
		OP_CLC = 8'h18,
		OP_SEC = 8'h38,
		OP_CLV = 8'hB8,
		OP_CLD = 8'hD8,
		OP_SED = 8'hF8
	} opcode_e;

	// Handshake controller states
	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_EXEC = 2'd1,
		ST_DONE = 2'd2
	} ctrl_state_e;

endpackage

// ==== alu_if.sv ====
`timescale 1ns/1ps

interface alu_if;

	// Issued operation, held by the controller
	cpu65_pkg::opcode_e opcode;
	logic [cpu65_pkg::DATA_W-1:0] operand;

	// Architectural state seen by the datapath
	logic [cpu65_pkg::DATA_W-1:0] acc;
	logic carry;
	logic decimal;

	modport issue (
		output opcode,
		output operand
	);

	modport arch (
		input  opcode,
		output acc,
		output carry,
		output decimal
	);

	modport unit (
		input opcode,
		input operand,
		input acc,
		input carry,
		input decimal
	);

endinterface

// ==== cpu65_ctrl.sv ====
`timescale 1ns/1ps

module cpu65_ctrl (
	input  logic                         PH0IN,
	input  logic                         rst_n,
	input  logic                         op_req_i,
	input  logic [cpu65_pkg::DATA_W-1:0] opcode_i,
	input  logic [cpu65_pkg::DATA_W-1:0] operand_i,
	output logic                         ack_o,
	output logic                         commit_o,
	alu_if.issue                         alu
);

	cpu65_pkg::ctrl_state_e state_q;
	cpu65_pkg::ctrl_state_e state_nxt;
	cpu65_pkg::opcode_e     opcode_q;
	logic [cpu65_pkg::DATA_W-1:0] operand_q;

	logic accept;

	assign accept = (state_q == cpu65_pkg::ST_IDLE) && op_req_i;

	// ------------------------------------------------------------------------
	// Four-phase handshake FSM
	// ------------------------------------------------------------------------
	always_comb begin
		state_nxt = state_q;
		case (state_q)
			cpu65_pkg::ST_IDLE: begin
				if (op_req_i)
					state_nxt = cpu65_pkg::ST_EXEC;
			end
			// Single cycle to commit the result
			cpu65_pkg::ST_EXEC: state_nxt = cpu65_pkg::ST_DONE;
			cpu65_pkg::ST_DONE: begin
				if (!op_req_i)
					state_nxt = cpu65_pkg::ST_IDLE;
			end
			default: state_nxt = cpu65_pkg::ST_IDLE;
		endcase
	end

	always_ff @(posedge PH0IN) begin
		if (!rst_n)
			state_q <= cpu65_pkg::ST_IDLE;
		else
			state_q <= state_nxt;
	end

	// Request capture
	always_ff @(posedge PH0IN) begin
		if (accept) begin
			opcode_q  <= cpu65_pkg::opcode_e'(opcode_i);
			operand_q <= operand_i;
		end
	end

	assign alu.opcode  = opcode_q;
	assign alu.operand = operand_q;

	assign commit_o = (state_q == cpu65_pkg::ST_EXEC);
	assign ack_o    = (state_q == cpu65_pkg::ST_DONE);

endmodule

// ==== cpu65_adder.sv ====
`timescale 1ns/1ps

module cpu65_adder (
	alu_if.unit                          alu,
	output logic [cpu65_pkg::DATA_W-1:0] sum_o,
	output logic                         carry_o,
	output logic                         overflow_o
);

	logic is_add;
	logic is_sub;
	logic is_cmp;
	logic dec_en;
	logic carry_in;

	logic [cpu65_pkg::DATA_W-1:0] in_a;
	logic [cpu65_pkg::DATA_W-1:0] in_b;

	logic [4:0] half_add;
	logic       bcd_half_carry;
	logic       half_carry;
	logic [3:0] upper_add_6;
	logic [1:0] upper_add_7;
	logic [4:0] upper_add;
	logic       carry6;
	logic       bcd_carry_out;
	logic [8:0] adder_out;

	logic       invalid_bcd_lo;
	logic       invalid_bcd_hi;
	logic [3:0] adjust_lo;
	logic [3:0] adjust_hi;
	logic [8:0] bcd_out;

	// ------------------------------------------------------------------------
	// Operation decode
	// ------------------------------------------------------------------------
	assign is_add = (alu.opcode == cpu65_pkg::OP_ADC);
	assign is_cmp = (alu.opcode == cpu65_pkg::OP_CMP);
	assign is_sub = (alu.opcode == cpu65_pkg::OP_SBC) || is_cmp;

	// Compare never runs in decimal mode
	assign dec_en   = alu.decimal && (is_add || (alu.opcode == cpu65_pkg::OP_SBC));
	assign carry_in = is_cmp ? 1'b1 : alu.carry;

	assign in_a = alu.acc;
	assign in_b = is_sub ? ~alu.operand : alu.operand;

	// ------------------------------------------------------------------------
	// Split adder, low nibble then bits 6:4 and bit 7
	// ------------------------------------------------------------------------
	assign half_add       = {1'b0, in_a[3:0]} + {1'b0, in_b[3:0]} + {4'b0, carry_in};
	assign bcd_half_carry = dec_en && (half_add[3:0] >= 4'd10);
	assign half_carry     = half_add[4] || (bcd_half_carry && is_add);

	// Bit 6 carry kept apart for overflow
	assign upper_add_6 = {1'b0, in_a[6:4]} + {1'b0, in_b[6:4]} + {3'b0, half_carry};
	assign upper_add_7 = {1'b0, in_a[7]} + {1'b0, in_b[7]} + {1'b0, upper_add_6[3]};
	assign upper_add   = {upper_add_7, upper_add_6[2:0]};
	assign carry6      = upper_add_6[3];

	assign bcd_carry_out = dec_en && (upper_add[3:0] >= 4'd10);
	assign adder_out     = {upper_add, half_add[3:0]} | {bcd_carry_out && is_add, 8'h00};

	// ------------------------------------------------------------------------
	// Decimal correction per nibble
	// ------------------------------------------------------------------------
	assign invalid_bcd_lo = (in_a[3:0] > 4'd9) && !(alu.operand[3:0] > 4'd9);
	assign invalid_bcd_hi = (in_a[7:4] > 4'd9) && !(alu.operand[7:4] > 4'd9);

	always_comb begin
		if (is_add) begin
			adjust_lo = half_carry ? cpu65_pkg::BCD_ADJ_ADD : 4'h0;
			adjust_hi = adder_out[8] ? cpu65_pkg::BCD_ADJ_ADD : 4'h0;
		end else begin
			// Subtract borrows when the nibble carry is clear
			adjust_lo = ((bcd_half_carry || !half_carry) && !invalid_bcd_lo) ?
				cpu65_pkg::BCD_ADJ_SUB : 4'h0;
			adjust_hi = ((bcd_carry_out || !adder_out[8]) && !invalid_bcd_hi) ?
				cpu65_pkg::BCD_ADJ_SUB : 4'h0;
		end
	end

	assign bcd_out = {adder_out[8], adder_out[7:4] + adjust_hi, adder_out[3:0] + adjust_lo};

	assign sum_o   = dec_en ? bcd_out[7:0] : adder_out[7:0];
	assign carry_o = adder_out[8];

	// Overflow from the carries into and out of bit 7
	assign overflow_o = (!(in_a[7] || in_b[7]) && carry6) || (in_a[7] && in_b[7] && !carry6);

endmodule

// ==== cpu65_logic.sv ====
`timescale 1ns/1ps

module cpu65_logic (
	alu_if.unit                          alu,
	output logic [cpu65_pkg::DATA_W-1:0] result_o,
	output logic                         carry_o
);

	logic is_shift;
	logic is_rotate;
	logic shift_right;
	logic fill_bit;

	logic [cpu65_pkg::DATA_W-1:0] left_rotated;
	logic [cpu65_pkg::DATA_W-1:0] right_rotated;

	assign is_shift = (alu.opcode == cpu65_pkg::OP_ASL) || (alu.opcode == cpu65_pkg::OP_ROL) ||
		(alu.opcode == cpu65_pkg::OP_LSR) || (alu.opcode == cpu65_pkg::OP_ROR);

	// Shift column encodes direction and rotate in the opcode
	assign is_rotate   = alu.opcode[5];
	assign shift_right = alu.opcode[6];
	assign fill_bit    = alu.carry && is_rotate;

	assign left_rotated  = {alu.acc[cpu65_pkg::DATA_W-2:0], fill_bit};
	assign right_rotated = {fill_bit, alu.acc[cpu65_pkg::DATA_W-1:1]};

	// ------------------------------------------------------------------------
	// Result select
	// ------------------------------------------------------------------------
	always_comb begin
		case (alu.opcode)
			cpu65_pkg::OP_ORA: result_o = alu.acc | alu.operand;
			cpu65_pkg::OP_AND: result_o = alu.acc & alu.operand;
			cpu65_pkg::OP_EOR: result_o = alu.acc ^ alu.operand;
			cpu65_pkg::OP_LDA: result_o = alu.operand;
			cpu65_pkg::OP_ASL,
			cpu65_pkg::OP_ROL,
			cpu65_pkg::OP_LSR,
			cpu65_pkg::OP_ROR: result_o = shift_right ? right_rotated : left_rotated;
			default:           result_o = alu.acc;
		endcase
	end

	// Bit shifted out, C passes through otherwise
	always_comb begin
		if (!is_shift)
			carry_o = alu.carry;
		else if (shift_right)
			carry_o = alu.acc[0];
		else
			carry_o = alu.acc[cpu65_pkg::DATA_W-1];
	end

endmodule

// ==== cpu65_writeback.sv ====
`timescale 1ns/1ps

module cpu65_writeback (
	input  logic                         PH0IN,
	input  logic                         rst_n,
	input  logic                         commit_i,
	input  logic [cpu65_pkg::DATA_W-1:0] sum_i,
	input  logic                         add_carry_i,
	input  logic                         overflow_i,
	input  logic [cpu65_pkg::DATA_W-1:0] logic_i,
	input  logic                         logic_carry_i,
	output logic [cpu65_pkg::DATA_W-1:0] acc_o,
	output logic [cpu65_pkg::DATA_W-1:0] status_o,
	alu_if.arch                          alu
);

	logic [cpu65_pkg::DATA_W-1:0] acc_q;
	logic [cpu65_pkg::DATA_W-1:0] acc_nxt;
	logic n_q, v_q, d_q, z_q, c_q;
	logic n_nxt, v_nxt, d_nxt, z_nxt, c_nxt;

	logic                         sel_add;
	logic [cpu65_pkg::DATA_W-1:0] result;
	logic                         result_c;

	// ------------------------------------------------------------------------
	// Result and flag selection
	// ------------------------------------------------------------------------
	assign sel_add = (alu.opcode == cpu65_pkg::OP_ADC) || (alu.opcode == cpu65_pkg::OP_SBC) ||
		(alu.opcode == cpu65_pkg::OP_CMP);
	assign result   = sel_add ? sum_i : logic_i;
	assign result_c = sel_add ? add_carry_i : logic_carry_i;

	always_comb begin
		acc_nxt = acc_q;
		n_nxt   = n_q;
		v_nxt   = v_q;
		d_nxt   = d_q;
		z_nxt   = z_q;
		c_nxt   = c_q;
		case (alu.opcode)
			cpu65_pkg::OP_ADC, cpu65_pkg::OP_SBC: begin
				acc_nxt = result;
				v_nxt   = overflow_i;
			end
			cpu65_pkg::OP_ORA, cpu65_pkg::OP_AND, cpu65_pkg::OP_EOR, cpu65_pkg::OP_LDA,
			cpu65_pkg::OP_ASL, cpu65_pkg::OP_ROL, cpu65_pkg::OP_LSR, cpu65_pkg::OP_ROR:
				acc_nxt = result;
			cpu65_pkg::OP_CLC: c_nxt = 1'b0;
			cpu65_pkg::OP_SEC: c_nxt = 1'b1;
			cpu65_pkg::OP_CLV: v_nxt = 1'b0;
			cpu65_pkg::OP_CLD: d_nxt = 1'b0;
			cpu65_pkg::OP_SED: d_nxt = 1'b1;
			default: ;
		endcase
		// Arithmetic, compare and logic all update N, Z and C
		if (sel_add || (alu.opcode inside {cpu65_pkg::OP_ORA,
			cpu65_pkg::OP_AND, cpu65_pkg::OP_EOR, cpu65_pkg::OP_LDA, cpu65_pkg::OP_ASL,
			cpu65_pkg::OP_ROL, cpu65_pkg::OP_LSR, cpu65_pkg::OP_ROR})) begin
			n_nxt = result[cpu65_pkg::DATA_W-1];
			z_nxt = (result == '0);
			c_nxt = result_c;
		end
	end

	always_ff @(posedge PH0IN) begin
		if (!rst_n) begin
			acc_q <= '0;
			{n_q, v_q, d_q, c_q} <= 4'b0000;
			z_q <= 1'b1;
		end else if (commit_i) begin
			acc_q <= acc_nxt;
			{n_q, v_q, d_q, z_q, c_q} <= {n_nxt, v_nxt, d_nxt, z_nxt, c_nxt};
		end
	end

	// Bits 5 and 4 read as one, I is fixed
	always_comb begin
		status_o = 8'h30;
		status_o[cpu65_pkg::FLAG_N] = n_q;
		status_o[cpu65_pkg::FLAG_V] = v_q;
		status_o[cpu65_pkg::FLAG_D] = d_q;
		status_o[cpu65_pkg::FLAG_I] = 1'b1;
		status_o[cpu65_pkg::FLAG_Z] = z_q;
		status_o[cpu65_pkg::FLAG_C] = c_q;
	end

	assign acc_o       = acc_q;
	assign alu.acc     = acc_q;
	assign alu.carry   = c_q;
	assign alu.decimal = d_q;

endmodule

// ==== cpu65_exec.sv ====
`timescale 1ns/1ps

module cpu65_exec (
	input  logic                         PH0IN,
	input  logic                         rst_n,
	input  logic                         op_req_i,
	input  logic [cpu65_pkg::DATA_W-1:0] opcode_i,
	input  logic [cpu65_pkg::DATA_W-1:0] operand_i,
	output logic                         ack_o,
	output logic [cpu65_pkg::DATA_W-1:0] acc_o,
	output logic [cpu65_pkg::DATA_W-1:0] status_o
);

	logic                         commit;
	logic [cpu65_pkg::DATA_W-1:0] add_sum;
	logic                         add_carry;
	logic                         add_overflow;
	logic [cpu65_pkg::DATA_W-1:0] logic_res;
	logic                         logic_carry;

	alu_if alu ();

	cpu65_ctrl u_ctrl (
		.PH0IN     (PH0IN),
		.rst_n     (rst_n),
		.op_req_i  (op_req_i),
		.opcode_i  (opcode_i),
		.operand_i (operand_i),
		.ack_o     (ack_o),
		.commit_o  (commit),
		.alu       (alu.issue)
	);

	// Both datapath halves evaluate every operation in parallel
	cpu65_adder u_adder (
		.alu        (alu.unit),
		.sum_o      (add_sum),
		.carry_o    (add_carry),
		.overflow_o (add_overflow)
	);

	cpu65_logic u_logic (
		.alu      (alu.unit),
		.result_o (logic_res),
		.carry_o  (logic_carry)
	);

	cpu65_writeback u_writeback (
		.PH0IN         (PH0IN),
		.rst_n         (rst_n),
		.commit_i      (commit),
		.sum_i         (add_sum),
		.add_carry_i   (add_carry),
		.overflow_i    (add_overflow),
		.logic_i       (logic_res),
		.logic_carry_i (logic_carry),
		.acc_o         (acc_o),
		.status_o      (status_o),
		.alu           (alu.arch)
	);

endmodule

// ==== tb_cpu65_assert.sv ====
`timescale 1ns/1ps

module tb_cpu65_assert (
	input logic PH0IN,
	input logic rst_n,
	input logic op_req_i,
	input logic ack_o
);

	// ------------------------------------------------------------------------
	// Four-phase handshake rules
	// ------------------------------------------------------------------------
	property ack_needs_req;
		@(posedge PH0IN) disable iff (!rst_n)
		$rose(ack_o) |-> $past(op_req_i);
	endproperty

	property ack_held_while_req;
		@(posedge PH0IN) disable iff (!rst_n)
		(ack_o && op_req_i) |=> ack_o;
	endproperty

	// Accept edge, commit edge, then ack
	property ack_two_edges_after_req;
		@(posedge PH0IN) disable iff (!rst_n)
		$rose(op_req_i) |=> !ack_o ##1 ack_o;
	endproperty

	property ack_drops_after_req_low;
		@(posedge PH0IN) disable iff (!rst_n)
		(ack_o && !op_req_i) |=> !ack_o;
	endproperty

	a_ack_needs_req: assert property (ack_needs_req) else $error("ack rose without a request");
	a_ack_held: assert property (ack_held_while_req) else $error("ack dropped while req high");
	a_ack_latency: assert property (ack_two_edges_after_req) else $error("ack latency wrong");
	a_ack_release: assert property (ack_drops_after_req_low) else $error("ack did not fall");

endmodule

bind cpu65_exec tb_cpu65_assert u_assert (
	.PH0IN    (PH0IN),
	.rst_n    (rst_n),
	.op_req_i (op_req_i),
	.ack_o    (ack_o)
);

// ==== tb_cpu65.sv ====
`timescale 1ns/1ps

module tb_cpu65;

	localparam int RESET_CYCLES = 16;
	localparam int REQ_BUDGET   = 400;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + REQ_BUDGET * 8;

	logic       PH0IN;
	logic       rst_n;
	logic       op_req_i;
	logic [7:0] opcode_i;
	logic [7:0] operand_i;
	logic       ack_o;
	logic [7:0] acc_o;
	logic [7:0] status_o;

	// Expected architectural state
	logic [7:0] exp_acc;
	logic       exp_n, exp_v, exp_d, exp_z, exp_c;

	cpu65_exec dut (
		.PH0IN     (PH0IN),
		.rst_n     (rst_n),
		.op_req_i  (op_req_i),
		.opcode_i  (opcode_i),
		.operand_i (operand_i),
		.ack_o     (ack_o),
		.acc_o     (acc_o),
		.status_o  (status_o)
	);

	initial begin
		PH0IN = 1'b0;
		forever #10 PH0IN = ~PH0IN;
	end

	task automatic end_with_failure(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [7:0] got,
		input logic [7:0] want);
		end_with_failure($sformatf("mismatch %s: got %h expected %h", name, got, want));
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge PH0IN);
		end_with_failure("Timeout: the handshake did not complete in the expected time");
	end

	function automatic logic [7:0] pack_status();
		logic [7:0] s;
		s = 8'h30;
		s[cpu65_pkg::FLAG_N] = exp_n;
		s[cpu65_pkg::FLAG_V] = exp_v;
		s[cpu65_pkg::FLAG_D] = exp_d;
		s[cpu65_pkg::FLAG_I] = 1'b1;
		s[cpu65_pkg::FLAG_Z] = exp_z;
		s[cpu65_pkg::FLAG_C] = exp_c;
		return s;
	endfunction

	task automatic set_nz(input logic [7:0] r);
		exp_n = r[7];
		exp_z = (r == 8'h00);
	endtask

	// ------------------------------------------------------------------------
	// Reference model of the 6502 accumulator instructions
	// ------------------------------------------------------------------------
	task automatic apply_model(input cpu65_pkg::opcode_e op, input logic [7:0] b8);
		int a, b, cin, sum, lo, hi;
		a = int'(exp_acc);
		b = int'(b8);
		cin = exp_c ? 1 : 0;
		case (op)
			cpu65_pkg::OP_ORA: exp_acc = exp_acc | b8;
			cpu65_pkg::OP_AND: exp_acc = exp_acc & b8;
			cpu65_pkg::OP_EOR: exp_acc = exp_acc ^ b8;
			cpu65_pkg::OP_LDA: exp_acc = b8;
			cpu65_pkg::OP_ADC: begin
				if (exp_d) begin
					lo = (a & 15) + (b & 15) + cin;
					if (lo > 9)
						lo = ((lo + 6) & 15) + 16;
					sum = (a & 240) + (b & 240) + lo;
					exp_v = ((~(a ^ b)) & (a ^ sum) & 128) != 0;
					if (sum >= 'hA0)
						sum = sum + 'h60;
				end else begin
					sum = a + b + cin;
					exp_v = ((~(a ^ b)) & (a ^ sum) & 128) != 0;
				end
				exp_c = sum > 255;
				exp_acc = 8'(sum);
			end
			cpu65_pkg::OP_SBC: begin
				sum = a + (255 - b) + cin;
				exp_v = ((a ^ b) & (a ^ sum) & 128) != 0;
				exp_c = sum > 255;
				exp_acc = 8'(sum);
				if (exp_d) begin
					lo = (a & 15) - (b & 15) - (1 - cin);
					hi = (a >> 4) - (b >> 4);
					if (lo < 0) begin
						lo = lo + 10;
						hi = hi - 1;
					end
					if (hi < 0)
						hi = hi + 10;
					exp_acc = 8'(hi * 16 + lo);
				end
			end
			cpu65_pkg::OP_CMP: begin
				sum = a + (255 - b) + 1;
				exp_c = sum > 255;
			end
			cpu65_pkg::OP_ASL: {exp_c, exp_acc} = {exp_acc, 1'b0};
			cpu65_pkg::OP_ROL: {exp_c, exp_acc} = {exp_acc, exp_c};
			cpu65_pkg::OP_LSR: {exp_acc, exp_c} = {1'b0, exp_acc};
			cpu65_pkg::OP_ROR: {exp_acc, exp_c} = {exp_c, exp_acc};
			cpu65_pkg::OP_CLC: exp_c = 1'b0;
			cpu65_pkg::OP_SEC: exp_c = 1'b1;
			cpu65_pkg::OP_CLV: exp_v = 1'b0;
			cpu65_pkg::OP_CLD: exp_d = 1'b0;
			cpu65_pkg::OP_SED: exp_d = 1'b1;
			default: ;
		endcase
		if (op == cpu65_pkg::OP_CMP)
			set_nz(8'(sum));
		else if (!(op inside {cpu65_pkg::OP_CLC, cpu65_pkg::OP_SEC, cpu65_pkg::OP_CLV,
			cpu65_pkg::OP_CLD, cpu65_pkg::OP_SED}))
			set_nz(exp_acc);
	endtask

	task automatic check_outputs();
		logic [7:0] want;
		want = pack_status();
		assert (acc_o === exp_acc) else report_mismatch("acc_o", acc_o, exp_acc);
		assert (status_o === want) else report_mismatch("status_o", status_o, want);
	endtask

	// Four-phase request, called and returning on a falling edge
	task automatic issue_op(input cpu65_pkg::opcode_e op, input logic [7:0] data);
		int unsigned gap;
		gap = $urandom % 3;
		repeat (gap) @(negedge PH0IN);
		op_req_i  = 1'b1;
		opcode_i  = op;
		operand_i = data;
		apply_model(op, data);
		@(negedge PH0IN);
		while (!ack_o)
			@(negedge PH0IN);
		check_outputs();
		gap = $urandom % 3;
		repeat (gap) @(negedge PH0IN);
		op_req_i  = 1'b0;
		operand_i = 8'($urandom);
		@(negedge PH0IN);
		while (ack_o)
			@(negedge PH0IN);
	endtask

	task automatic set_carry_random();
		if ($urandom % 2 == 0)
			issue_op(cpu65_pkg::OP_SEC, 8'h00);
		else
			issue_op(cpu65_pkg::OP_CLC, 8'h00);
	endtask

	function automatic logic [7:0] rand_bcd();
		return 8'(($urandom % 10) * 16 + ($urandom % 10));
	endfunction

	initial begin
		void'($urandom(69));
		rst_n     = 1'b0;
		op_req_i  = 1'b0;
		opcode_i  = 8'h00;
		operand_i = 8'h00;
		exp_acc   = 8'h00;
		{exp_n, exp_v, exp_d, exp_z, exp_c} = 5'b00010;
		repeat (RESET_CYCLES) @(negedge PH0IN);
		rst_n = 1'b1;
		assert (ack_o === 1'b0) else report_mismatch("ack_o", 8'(ack_o), 8'h00);
		check_outputs();

		// V set so the logic group shows it is left alone
		issue_op(cpu65_pkg::OP_CLC, 8'h00);
		issue_op(cpu65_pkg::OP_LDA, 8'h50);
		issue_op(cpu65_pkg::OP_ADC, 8'h50);

		// Logic group
		repeat (80) begin
			set_carry_random();
			case ($urandom % 4)
				0: issue_op(cpu65_pkg::OP_ORA, 8'($urandom));
				1: issue_op(cpu65_pkg::OP_AND, 8'($urandom));
				2: issue_op(cpu65_pkg::OP_EOR, 8'($urandom));
				default: issue_op(cpu65_pkg::OP_LDA, 8'($urandom));
			endcase
		end

		// Binary arithmetic and compare
		repeat (40) begin
			issue_op(cpu65_pkg::OP_LDA, 8'($urandom));
			set_carry_random();
			case ($urandom % 3)
				0: issue_op(cpu65_pkg::OP_ADC, 8'($urandom));
				1: issue_op(cpu65_pkg::OP_SBC, 8'($urandom));
				default: issue_op(cpu65_pkg::OP_CMP, 8'($urandom));
			endcase
		end

		// Decimal mode
		issue_op(cpu65_pkg::OP_SED, 8'h00);
		repeat (20) begin
			issue_op(cpu65_pkg::OP_LDA, rand_bcd());
			set_carry_random();
			if ($urandom % 2 == 0)
				issue_op(cpu65_pkg::OP_ADC, rand_bcd());
			else
				issue_op(cpu65_pkg::OP_SBC, rand_bcd());
		end
		issue_op(cpu65_pkg::OP_CLD, 8'h00);
		issue_op(cpu65_pkg::OP_LDA, 8'h19);
		issue_op(cpu65_pkg::OP_ADC, 8'h28);

		// Shifts and rotates through C
		repeat (20) begin
			issue_op(cpu65_pkg::OP_LDA, 8'($urandom));
			set_carry_random();
			case ($urandom % 4)
				0: issue_op(cpu65_pkg::OP_ASL, 8'($urandom));
				1: issue_op(cpu65_pkg::OP_ROL, 8'($urandom));
				2: issue_op(cpu65_pkg::OP_LSR, 8'($urandom));
				default: issue_op(cpu65_pkg::OP_ROR, 8'($urandom));
			endcase
		end

		// Force V set, then clear it
		issue_op(cpu65_pkg::OP_CLC, 8'h00);
		issue_op(cpu65_pkg::OP_LDA, 8'h50);
		issue_op(cpu65_pkg::OP_ADC, 8'h50);
		issue_op(cpu65_pkg::OP_CLV, 8'h00);
		issue_op(cpu65_pkg::OP_SEC, 8'h00);
		issue_op(cpu65_pkg::OP_CLC, 8'h00);

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// ==== project.f ====
cpu65_pkg.sv
alu_if.sv
cpu65_ctrl.sv
cpu65_adder.sv
cpu65_logic.sv
cpu65_writeback.sv
cpu65_exec.sv
tb_cpu65_assert.sv
tb_cpu65.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tb_cpu65 -o sim_cpu65

./obj_dir/sim_cpu65 > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation completed successfully" sim.log; then
	exit 0
else
	exit 1
fi
